/* hw/l2_settings.svh */
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// Geometry of the L2 metadata arrays
`define L2_NUM_SETS 16
`define L2_SET_INDEX_WIDTH 4

// Width of the tag kept per line
`define L2_TAG_WIDTH 12

// A line address is the tag followed by the set index in the low bits
`define L2_ADDR_WIDTH 16

// Fixed at four by the two-bit way fields and the three-bit LRU tree
`define L2_NUM_WAYS 4

`endif

/* hw/l2_pkg.sv */
`include "l2_settings.svh"
`default_nettype none

package l2_pkg;

	// Operations a request can carry through the tag pipeline
	typedef enum logic [1:0]
	{
		L2_OP_READ = 2'd0,
		L2_OP_WRITE = 2'd1,
		L2_OP_FLUSH = 2'd2
	} l2_op_t;

	// Tag stored per way, also used on the ports between the stages
	typedef logic [`L2_TAG_WIDTH - 1:0] l2_tag_t;

endpackage

`default_nettype wire

/* hw/sram_1r1w.sv */
`timescale 1ns/1ps
`default_nettype none

// Synchronous memory with one read and one write port.
// The read data is registered and held while no read is requested
module sram_1r1w
	#(parameter type entry_t = logic,
	parameter int NUM_ENTRIES = 16,
	parameter int ADDR_WIDTH = 4)
	(input wire logic clk,
	input wire logic rd_enable_i,
	input wire logic [ADDR_WIDTH - 1:0] rd_addr_i,
	output entry_t rd_data_o,
	input wire logic wr_enable_i,
	input wire logic [ADDR_WIDTH - 1:0] wr_addr_i,
	input wire entry_t wr_data_i);

	entry_t mem [NUM_ENTRIES];

	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// A read of the address being written in the same cycle returns the old contents
	always_ff @(posedge clk)
	begin
		if (rd_enable_i)
			rd_data_o <= mem[rd_addr_i];
	end

	rd_addr_in_range: assert property (@(posedge clk)
		rd_enable_i |-> rd_addr_i < NUM_ENTRIES);

	wr_addr_in_range: assert property (@(posedge clk)
		wr_enable_i |-> wr_addr_i < NUM_ENTRIES);

endmodule

`default_nettype wire

/* hw/cache_lru.sv */
`timescale 1ns/1ps
`default_nettype none

// Tree pseudo-LRU for a four-way cache.
// Bit 0 chooses the victim pair, bit 1 the way within pair 0/1
// and bit 2 the way within pair 2/3
module cache_lru
	#(parameter int NUM_SETS = 16,
	parameter int SET_INDEX_WIDTH = 4)
	(input wire logic clk,
	input wire logic reset,
	input wire logic rd_enable_i,
	input wire logic [SET_INDEX_WIDTH - 1:0] set_i,
	output logic [1:0] lru_way_o,
	input wire logic update_i,
	input wire logic [SET_INDEX_WIDTH - 1:0] update_set_i,
	input wire logic [1:0] mru_way_i);

	logic [2:0] tree [NUM_SETS];
	logic [2:0] updated_tree;
	logic [2:0] read_tree;

	function automatic logic [1:0] victim_of(input logic [2:0] bits);
		if (bits[0])
			return bits[2] ? 2'd3 : 2'd2;
		else
			return bits[1] ? 2'd1 : 2'd0;
	endfunction

	// Point the root away from the pair of the used way, and the
	// pair bit at the other way of that pair
	always_comb
	begin
		updated_tree = tree[update_set_i];
		updated_tree[0] = ~mru_way_i[1];
		if (mru_way_i[1])
			updated_tree[2] = ~mru_way_i[0];
		else
			updated_tree[1] = ~mru_way_i[0];
	end

	// A lookup of the set updated at the same edge must see the new tree
	assign read_tree = (update_i && update_set_i == set_i) ? updated_tree : tree[set_i];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				tree[s] <= 3'b000;

			lru_way_o <= 2'd0;
		end
		else
		begin
			if (update_i)
				tree[update_set_i] <= updated_tree;

			if (rd_enable_i)
				lru_way_o <= victim_of(read_tree);
		end
	end

endmodule

`default_nettype wire

/* hw/l2_tag_stage.sv */
`timescale 1ns/1ps
`include "l2_settings.svh"
`default_nettype none

// First pipeline stage. Issues the metadata reads for all four ways and
// registers the request, so the next stage sees both one cycle later
module l2_tag_stage
	(input wire logic clk,
	input wire logic reset,
	input wire logic stall_i,
	input wire logic req_valid_i,
	input wire l2_pkg::l2_op_t req_op_i,
	input wire logic [`L2_ADDR_WIDTH - 1:0] req_addr_i,
	input wire logic upd_tag_en_i,
	input wire logic [1:0] upd_way_i,
	input wire logic [`L2_SET_INDEX_WIDTH - 1:0] upd_set_i,
	input wire l2_pkg::l2_tag_t upd_tag_i,
	input wire logic upd_valid_i,
	input wire logic upd_dirty_en_i,
	input wire logic upd_dirty_i,
	input wire logic upd_lru_en_i,
	input wire logic [1:0] upd_mru_way_i,
	output logic tag_valid_o,
	output l2_pkg::l2_op_t tag_op_o,
	output logic [`L2_ADDR_WIDTH - 1:0] tag_addr_o,
	output l2_pkg::l2_tag_t tag_way_tag0_o,
	output l2_pkg::l2_tag_t tag_way_tag1_o,
	output l2_pkg::l2_tag_t tag_way_tag2_o,
	output l2_pkg::l2_tag_t tag_way_tag3_o,
	output logic tag_way_valid0_o,
	output logic tag_way_valid1_o,
	output logic tag_way_valid2_o,
	output logic tag_way_valid3_o,
	output logic tag_way_dirty0_o,
	output logic tag_way_dirty1_o,
	output logic tag_way_dirty2_o,
	output logic tag_way_dirty3_o,
	output logic [1:0] tag_lru_way_o);

	logic [`L2_SET_INDEX_WIDTH - 1:0] req_set;
	logic read_en;
	logic same_set;
	logic [`L2_NUM_WAYS - 1:0] upd_tag_way;
	logic [`L2_NUM_WAYS - 1:0] upd_dirty_way;
	logic [`L2_NUM_SETS - 1:0] valid_bits [`L2_NUM_WAYS];
	l2_pkg::l2_tag_t sram_tag [`L2_NUM_WAYS];
	logic sram_dirty [`L2_NUM_WAYS];
	l2_pkg::l2_tag_t way_tag [`L2_NUM_WAYS];
	logic [`L2_NUM_WAYS - 1:0] way_dirty;
	logic [`L2_NUM_WAYS - 1:0] way_valid_q;
	logic [`L2_NUM_WAYS - 1:0] fwd_tag_q;
	logic [`L2_NUM_WAYS - 1:0] fwd_dirty_q;
	l2_pkg::l2_tag_t fwd_tag_data_q;
	logic fwd_dirty_data_q;

	assign req_set = req_addr_i[`L2_SET_INDEX_WIDTH - 1:0];
	assign read_en = req_valid_i && !stall_i;
	assign same_set = upd_set_i == req_set;

	for (genvar w = 0; w < `L2_NUM_WAYS; w++)
	begin : gen_way
		assign upd_tag_way[w] = upd_tag_en_i && upd_way_i == 2'(w);
		assign upd_dirty_way[w] = upd_dirty_en_i && upd_way_i == 2'(w);

		sram_1r1w #(
			.entry_t(l2_pkg::l2_tag_t),
			.NUM_ENTRIES(`L2_NUM_SETS),
			.ADDR_WIDTH(`L2_SET_INDEX_WIDTH)
		) tag_mem (
			.clk(clk),
			.rd_enable_i(read_en),
			.rd_addr_i(req_set),
			.rd_data_o(sram_tag[w]),
			.wr_enable_i(upd_tag_way[w]),
			.wr_addr_i(upd_set_i),
			.wr_data_i(upd_tag_i));

		sram_1r1w #(
			.entry_t(logic),
			.NUM_ENTRIES(`L2_NUM_SETS),
			.ADDR_WIDTH(`L2_SET_INDEX_WIDTH)
		) dirty_mem (
			.clk(clk),
			.rd_enable_i(read_en),
			.rd_addr_i(req_set),
			.rd_data_o(sram_dirty[w]),
			.wr_enable_i(upd_dirty_way[w]),
			.wr_addr_i(upd_set_i),
			.wr_data_i(upd_dirty_i));

		// The SRAMs return stale data for a set written at the read edge
		assign way_tag[w] = fwd_tag_q[w] ? fwd_tag_data_q : sram_tag[w];
		assign way_dirty[w] = fwd_dirty_q[w] ? fwd_dirty_data_q : sram_dirty[w];
	end

	cache_lru #(
		.NUM_SETS(`L2_NUM_SETS),
		.SET_INDEX_WIDTH(`L2_SET_INDEX_WIDTH)
	) lru (
		.clk(clk),
		.reset(reset),
		.rd_enable_i(read_en),
		.set_i(req_set),
		.lru_way_o(tag_lru_way_o),
		.update_i(upd_lru_en_i),
		.update_set_i(upd_set_i),
		.mru_way_i(upd_mru_way_i));

	// Valid bits live in flops so that reset can clear every line
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int w = 0; w < `L2_NUM_WAYS; w++)
				valid_bits[w] <= '0;
		end
		else
		begin
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				if (upd_tag_way[w])
					valid_bits[w][upd_set_i] <= upd_valid_i;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tag_valid_o <= 1'b0;
			way_valid_q <= '0;
			fwd_tag_q <= '0;
			fwd_dirty_q <= '0;
		end
		else if (!stall_i)
		begin
			tag_valid_o <= req_valid_i;
			if (req_valid_i)
			begin
				fwd_tag_q <= upd_tag_way & {`L2_NUM_WAYS{same_set}};
				fwd_dirty_q <= upd_dirty_way & {`L2_NUM_WAYS{same_set}};
				for (int w = 0; w < `L2_NUM_WAYS; w++)
					way_valid_q[w] <= (upd_tag_way[w] && same_set) ? upd_valid_i
						: valid_bits[w][req_set];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (read_en)
		begin
			tag_op_o <= req_op_i;
			tag_addr_o <= req_addr_i;
			fwd_tag_data_q <= upd_tag_i;
			fwd_dirty_data_q <= upd_dirty_i;
		end
	end

	assign tag_way_tag0_o = way_tag[0];
	assign tag_way_tag1_o = way_tag[1];
	assign tag_way_tag2_o = way_tag[2];
	assign tag_way_tag3_o = way_tag[3];
	assign tag_way_valid0_o = way_valid_q[0];
	assign tag_way_valid1_o = way_valid_q[1];
	assign tag_way_valid2_o = way_valid_q[2];
	assign tag_way_valid3_o = way_valid_q[3];
	assign tag_way_dirty0_o = way_dirty[0];
	assign tag_way_dirty1_o = way_dirty[1];
	assign tag_way_dirty2_o = way_dirty[2];
	assign tag_way_dirty3_o = way_dirty[3];

	// Every accepted request must carry one of the defined operations
	req_op_known: assert property (@(posedge clk) disable iff (reset)
		read_en |-> req_op_i inside {l2_pkg::L2_OP_READ, l2_pkg::L2_OP_WRITE,
			l2_pkg::L2_OP_FLUSH});

endmodule

`default_nettype wire

/* hw/l2_update_stage.sv */
`timescale 1ns/1ps
`include "l2_settings.svh"
`default_nettype none

// Second pipeline stage. Decides hit or miss, picks the way to use,
// writes the new metadata back into the tag stage and registers the response
module l2_update_stage
	(input wire logic clk,
	input wire logic reset,
	input wire logic stall_i,
	input wire logic tag_valid_i,
	input wire l2_pkg::l2_op_t tag_op_i,
	input wire logic [`L2_ADDR_WIDTH - 1:0] tag_addr_i,
	input wire l2_pkg::l2_tag_t tag_way_tag0_i,
	input wire l2_pkg::l2_tag_t tag_way_tag1_i,
	input wire l2_pkg::l2_tag_t tag_way_tag2_i,
	input wire l2_pkg::l2_tag_t tag_way_tag3_i,
	input wire logic tag_way_valid0_i,
	input wire logic tag_way_valid1_i,
	input wire logic tag_way_valid2_i,
	input wire logic tag_way_valid3_i,
	input wire logic tag_way_dirty0_i,
	input wire logic tag_way_dirty1_i,
	input wire logic tag_way_dirty2_i,
	input wire logic tag_way_dirty3_i,
	input wire logic [1:0] tag_lru_way_i,
	output logic upd_tag_en_o,
	output logic [1:0] upd_way_o,
	output logic [`L2_SET_INDEX_WIDTH - 1:0] upd_set_o,
	output l2_pkg::l2_tag_t upd_tag_o,
	output logic upd_valid_o,
	output logic upd_dirty_en_o,
	output logic upd_dirty_o,
	output logic upd_lru_en_o,
	output logic [1:0] upd_mru_way_o,
	output logic resp_valid_o,
	output l2_pkg::l2_op_t resp_op_o,
	output logic [`L2_ADDR_WIDTH - 1:0] resp_addr_o,
	output logic resp_hit_o,
	output logic [1:0] resp_way_o,
	output logic resp_writeback_o,
	output logic [`L2_ADDR_WIDTH - 1:0] resp_victim_addr_o);

	l2_pkg::l2_tag_t req_tag;
	logic [`L2_SET_INDEX_WIDTH - 1:0] req_set;
	l2_pkg::l2_tag_t way_tag [`L2_NUM_WAYS];
	logic [`L2_NUM_WAYS - 1:0] way_valid;
	logic [`L2_NUM_WAYS - 1:0] way_dirty;
	logic [`L2_NUM_WAYS - 1:0] way_match;
	logic [1:0] hit_way;
	logic [1:0] alloc_way;
	logic [1:0] used_way;
	logic hit;
	logic is_flush;
	logic is_write;
	logic replace;
	logic active;
	logic writeback;

	assign req_tag = tag_addr_i[`L2_ADDR_WIDTH - 1:`L2_SET_INDEX_WIDTH];
	assign req_set = tag_addr_i[`L2_SET_INDEX_WIDTH - 1:0];
	assign way_tag = '{tag_way_tag0_i, tag_way_tag1_i, tag_way_tag2_i, tag_way_tag3_i};
	assign way_valid = {tag_way_valid3_i, tag_way_valid2_i, tag_way_valid1_i, tag_way_valid0_i};
	assign way_dirty = {tag_way_dirty3_i, tag_way_dirty2_i, tag_way_dirty1_i, tag_way_dirty0_i};

	always_comb
	begin
		for (int w = 0; w < `L2_NUM_WAYS; w++)
			way_match[w] = way_valid[w] && way_tag[w] == req_tag;
	end

	// Scanning downwards leaves the lowest matching or free way selected
	always_comb
	begin
		hit_way = 2'd0;
		alloc_way = tag_lru_way_i;
		for (int w = `L2_NUM_WAYS - 1; w >= 0; w--)
		begin
			if (way_match[w])
				hit_way = 2'(w);

			if (!way_valid[w])
				alloc_way = 2'(w);
		end
	end

	assign hit = |way_match;
	assign used_way = hit ? hit_way : alloc_way;
	assign is_flush = tag_op_i == l2_pkg::L2_OP_FLUSH;
	assign is_write = tag_op_i == l2_pkg::L2_OP_WRITE;
	assign active = tag_valid_i && !stall_i;

	// The line in used_way changes identity on a fill, or goes away on a flush hit
	assign replace = is_flush ? hit : !hit;
	assign writeback = replace && way_valid[used_way] && way_dirty[used_way];

	assign upd_tag_en_o = active && replace;
	assign upd_way_o = used_way;
	assign upd_set_o = req_set;
	assign upd_tag_o = req_tag;
	assign upd_valid_o = !is_flush;

	// Writes mark the line dirty, fills and flushes leave it clean
	assign upd_dirty_en_o = active && (is_write || replace);
	assign upd_dirty_o = is_write;

	assign upd_lru_en_o = active && !is_flush;
	assign upd_mru_way_o = used_way;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			resp_valid_o <= 1'b0;
		else if (!stall_i)
			resp_valid_o <= tag_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (active)
		begin
			resp_op_o <= tag_op_i;
			resp_addr_o <= tag_addr_i;
			resp_hit_o <= hit;
			resp_way_o <= (is_flush && !hit) ? 2'd0 : used_way;
			resp_writeback_o <= writeback;
			resp_victim_addr_o <= {way_tag[used_way], req_set};
		end
	end

	// Allocation only fills a way on a miss, so a line never sits in two ways
	one_way_match: assert property (@(posedge clk) disable iff (reset)
		tag_valid_i |-> $onehot0(way_match));

endmodule

`default_nettype wire

/* hw/l2_tag_pipeline.sv */
`timescale 1ns/1ps
`include "l2_settings.svh"
`default_nettype none

// Two-stage L2 tag pipeline: metadata lookup followed by hit check and update
module l2_tag_pipeline
	(input wire logic clk,
	input wire logic reset,
	input wire logic stall_i,
	input wire logic req_valid_i,
	input wire l2_pkg::l2_op_t req_op_i,
	input wire logic [`L2_ADDR_WIDTH - 1:0] req_addr_i,
	output logic resp_valid_o,
	output l2_pkg::l2_op_t resp_op_o,
	output logic [`L2_ADDR_WIDTH - 1:0] resp_addr_o,
	output logic resp_hit_o,
	output logic [1:0] resp_way_o,
	output logic resp_writeback_o,
	output logic [`L2_ADDR_WIDTH - 1:0] resp_victim_addr_o);

	logic tag_valid;
	l2_pkg::l2_op_t tag_op;
	logic [`L2_ADDR_WIDTH - 1:0] tag_addr;
	l2_pkg::l2_tag_t tag_way_tag0;
	l2_pkg::l2_tag_t tag_way_tag1;
	l2_pkg::l2_tag_t tag_way_tag2;
	l2_pkg::l2_tag_t tag_way_tag3;
	logic tag_way_valid0;
	logic tag_way_valid1;
	logic tag_way_valid2;
	logic tag_way_valid3;
	logic tag_way_dirty0;
	logic tag_way_dirty1;
	logic tag_way_dirty2;
	logic tag_way_dirty3;
	logic [1:0] tag_lru_way;
	logic upd_tag_en;
	logic [1:0] upd_way;
	logic [`L2_SET_INDEX_WIDTH - 1:0] upd_set;
	l2_pkg::l2_tag_t upd_tag;
	logic upd_valid;
	logic upd_dirty_en;
	logic upd_dirty;
	logic upd_lru_en;
	logic [1:0] upd_mru_way;

	l2_tag_stage tag_stage (
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.req_valid_i(req_valid_i),
		.req_op_i(req_op_i),
		.req_addr_i(req_addr_i),
		.upd_tag_en_i(upd_tag_en),
		.upd_way_i(upd_way),
		.upd_set_i(upd_set),
		.upd_tag_i(upd_tag),
		.upd_valid_i(upd_valid),
		.upd_dirty_en_i(upd_dirty_en),
		.upd_dirty_i(upd_dirty),
		.upd_lru_en_i(upd_lru_en),
		.upd_mru_way_i(upd_mru_way),
		.tag_valid_o(tag_valid),
		.tag_op_o(tag_op),
		.tag_addr_o(tag_addr),
		.tag_way_tag0_o(tag_way_tag0),
		.tag_way_tag1_o(tag_way_tag1),
		.tag_way_tag2_o(tag_way_tag2),
		.tag_way_tag3_o(tag_way_tag3),
		.tag_way_valid0_o(tag_way_valid0),
		.tag_way_valid1_o(tag_way_valid1),
		.tag_way_valid2_o(tag_way_valid2),
		.tag_way_valid3_o(tag_way_valid3),
		.tag_way_dirty0_o(tag_way_dirty0),
		.tag_way_dirty1_o(tag_way_dirty1),
		.tag_way_dirty2_o(tag_way_dirty2),
		.tag_way_dirty3_o(tag_way_dirty3),
		.tag_lru_way_o(tag_lru_way));

	l2_update_stage update_stage (
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.tag_valid_i(tag_valid),
		.tag_op_i(tag_op),
		.tag_addr_i(tag_addr),
		.tag_way_tag0_i(tag_way_tag0),
		.tag_way_tag1_i(tag_way_tag1),
		.tag_way_tag2_i(tag_way_tag2),
		.tag_way_tag3_i(tag_way_tag3),
		.tag_way_valid0_i(tag_way_valid0),
		.tag_way_valid1_i(tag_way_valid1),
		.tag_way_valid2_i(tag_way_valid2),
		.tag_way_valid3_i(tag_way_valid3),
		.tag_way_dirty0_i(tag_way_dirty0),
		.tag_way_dirty1_i(tag_way_dirty1),
		.tag_way_dirty2_i(tag_way_dirty2),
		.tag_way_dirty3_i(tag_way_dirty3),
		.tag_lru_way_i(tag_lru_way),
		.upd_tag_en_o(upd_tag_en),
		.upd_way_o(upd_way),
		.upd_set_o(upd_set),
		.upd_tag_o(upd_tag),
		.upd_valid_o(upd_valid),
		.upd_dirty_en_o(upd_dirty_en),
		.upd_dirty_o(upd_dirty),
		.upd_lru_en_o(upd_lru_en),
		.upd_mru_way_o(upd_mru_way),
		.resp_valid_o(resp_valid_o),
		.resp_op_o(resp_op_o),
		.resp_addr_o(resp_addr_o),
		.resp_hit_o(resp_hit_o),
		.resp_way_o(resp_way_o),
		.resp_writeback_o(resp_writeback_o),
		.resp_victim_addr_o(resp_victim_addr_o));

endmodule

`default_nettype wire

/* verification/tb_l2_tag_pipeline.sv */
`timescale 1ns/1ps
`include "l2_settings.svh"
`default_nettype none

module tb_l2_tag_pipeline;

	localparam int RANDOM_REQUESTS = 200;
	localparam int TOTAL_REQUESTS = 32 + 5 + 5 + 6 + RANDOM_REQUESTS;

	typedef struct packed
	{
		l2_pkg::l2_op_t op;
		logic [`L2_ADDR_WIDTH - 1:0] addr;
		logic hit;
		logic [1:0] way;
		logic writeback;
		logic [`L2_ADDR_WIDTH - 1:0] victim;
	} expect_t;

	logic clk;
	logic reset;
	logic stall_i;
	logic req_valid_i;
	l2_pkg::l2_op_t req_op_i;
	logic [`L2_ADDR_WIDTH - 1:0] req_addr_i;
	logic resp_valid_o;
	l2_pkg::l2_op_t resp_op_o;
	logic [`L2_ADDR_WIDTH - 1:0] resp_addr_o;
	logic resp_hit_o;
	logic [1:0] resp_way_o;
	logic resp_writeback_o;
	logic [`L2_ADDR_WIDTH - 1:0] resp_victim_addr_o;

	// Reference copy of the metadata held by the cache
	logic [`L2_TAG_WIDTH - 1:0] model_tag [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic model_valid [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic model_dirty [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic [2:0] model_tree [`L2_NUM_SETS];

	expect_t expect_q [$];
	expect_t expected_resp;
	logic [31:0] lfsr_state = 32'hbaffb199;
	logic random_stall = 1'b0;
	int cycle_count = 0;
	int stall_cycles = 0;
	int error_count = 0;
	int test_errors = 0;
	int accepted_count = 0;
	int resp_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	l2_tag_pipeline l2_tag_pipeline_i (
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.req_valid_i(req_valid_i),
		.req_op_i(req_op_i),
		.req_addr_i(req_addr_i),
		.resp_valid_o(resp_valid_o),
		.resp_op_o(resp_op_o),
		.resp_addr_o(resp_addr_o),
		.resp_hit_o(resp_hit_o),
		.resp_way_o(resp_way_o),
		.resp_writeback_o(resp_writeback_o),
		.resp_victim_addr_o(resp_victim_addr_o));

	always #50 clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic logic [15:0] random_bits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[14:0], lfsr_bit()};
		return value;
	endfunction

	function automatic int tree_victim(input logic [2:0] bits);
		case ({bits[0], bits[2], bits[1]})
			3'b000, 3'b010: return 0;
			3'b001, 3'b011: return 1;
			3'b100, 3'b101: return 2;
			default: return 3;
		endcase
	endfunction

	// The root points at the pair not used, the pair bit at the unused way
	function automatic logic [2:0] tree_touch(input logic [2:0] bits, input logic [1:0] way);
		logic [2:0] next;
		next = bits;
		case (way)
			2'd0: next = {bits[2], 1'b1, 1'b1};
			2'd1: next = {bits[2], 1'b0, 1'b1};
			2'd2: next = {1'b1, bits[1], 1'b0};
			default: next = {1'b0, bits[1], 1'b0};
		endcase
		return next;
	endfunction

	// Applies one request to the model and returns the response it should produce
	function automatic expect_t reference_access(input l2_pkg::l2_op_t op,
		input logic [`L2_ADDR_WIDTH - 1:0] addr);
		expect_t result;
		logic [`L2_SET_INDEX_WIDTH - 1:0] set_idx;
		logic [`L2_TAG_WIDTH - 1:0] tag;
		int way;
		set_idx = addr[`L2_SET_INDEX_WIDTH - 1:0];
		tag = addr[`L2_ADDR_WIDTH - 1:`L2_SET_INDEX_WIDTH];
		result = '0;
		result.op = op;
		result.addr = addr;
		way = -1;
		for (int w = `L2_NUM_WAYS - 1; w >= 0; w--)
			if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
				way = w;
		result.hit = way >= 0;
		if (op == l2_pkg::L2_OP_FLUSH)
		begin
			if (result.hit)
			begin
				result.way = 2'(way);
				result.writeback = model_dirty[set_idx][way];
				result.victim = addr;
				model_valid[set_idx][way] = 1'b0;
				model_dirty[set_idx][way] = 1'b0;
			end
			return result;
		end
		if (!result.hit)
		begin
			for (int w = `L2_NUM_WAYS - 1; w >= 0; w--)
				if (!model_valid[set_idx][w])
					way = w;
			if (way < 0)
				way = tree_victim(model_tree[set_idx]);
			result.writeback = model_valid[set_idx][way] && model_dirty[set_idx][way];
			result.victim = {model_tag[set_idx][way], set_idx};
			model_tag[set_idx][way] = tag;
			model_valid[set_idx][way] = 1'b1;
			model_dirty[set_idx][way] = 1'b0;
		end
		if (op == l2_pkg::L2_OP_WRITE)
			model_dirty[set_idx][way] = 1'b1;
		result.way = 2'(way);
		model_tree[set_idx] = tree_touch(model_tree[set_idx], 2'(way));
		return result;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] expected, input logic [15:0] addr);
		$display("ERR %s got %h expected %h for address %h", name, got, expected, addr);
		error_count++;
	endtask

	// Holds the request until an unstalled edge accepts it
	task automatic issue(input l2_pkg::l2_op_t op, input logic [`L2_ADDR_WIDTH - 1:0] addr);
		logic accepted;
		accepted = 1'b0;
		req_valid_i <= 1'b1;
		req_op_i <= op;
		req_addr_i <= addr;
		stall_i <= random_stall ? lfsr_bit() : 1'b0;
		while (!accepted)
		begin
			@(posedge clk);
			if (stall_i)
			begin
				stall_cycles++;
				stall_i <= random_stall ? lfsr_bit() : 1'b0;
			end
			else
				accepted = 1'b1;
		end
		accepted_count++;
		expect_q.push_back(reference_access(op, addr));
	endtask

	task automatic start_test();
		test_errors = error_count;
		accepted_count = 0;
		resp_count = 0;
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (int s = 0; s < `L2_NUM_SETS; s++)
		begin
			model_tree[s] = 3'b000;
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				model_tag[s][w] = '0;
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
			end
		end
		@(posedge clk);
	endtask

	task automatic finish_test(input string name);
		req_valid_i <= 1'b0;
		stall_i <= 1'b0;
		while (expect_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (resp_count != accepted_count)
		begin
			$display("Got %0d responses for %0d accepted requests", resp_count, accepted_count);
			error_count++;
		end
		if (error_count == test_errors)
		begin
			tests_passed++;
			$display("PASS %s", name);
		end
		else
		begin
			tests_failed++;
			$display("FAIL %s with %0d errors", name, error_count - test_errors);
		end
	endtask

	// A response is taken in the cycle that ends with an unstalled edge
	always @(negedge clk)
	begin
		if (!reset && resp_valid_o && !stall_i)
		begin
			resp_count++;
			if (expect_q.size() == 0)
			begin
				$display("Response for address %h arrived with no request outstanding",
					resp_addr_o);
				error_count++;
			end
			else
			begin
				expected_resp = expect_q.pop_front();
				if (resp_op_o !== expected_resp.op)
					report_mismatch("resp_op_o", 16'(resp_op_o), 16'(expected_resp.op),
						expected_resp.addr);
				if (resp_addr_o !== expected_resp.addr)
					report_mismatch("resp_addr_o", resp_addr_o, expected_resp.addr,
						expected_resp.addr);
				if (resp_hit_o !== expected_resp.hit)
					report_mismatch("resp_hit_o", 16'(resp_hit_o), 16'(expected_resp.hit),
						expected_resp.addr);
				if ((expected_resp.op != l2_pkg::L2_OP_FLUSH || expected_resp.hit)
					&& resp_way_o !== expected_resp.way)
					report_mismatch("resp_way_o", 16'(resp_way_o), 16'(expected_resp.way),
						expected_resp.addr);
				if (resp_writeback_o !== expected_resp.writeback)
					report_mismatch("resp_writeback_o", 16'(resp_writeback_o),
						16'(expected_resp.writeback), expected_resp.addr);
				if (expected_resp.writeback && resp_victim_addr_o !== expected_resp.victim)
					report_mismatch("resp_victim_addr_o", resp_victim_addr_o,
						expected_resp.victim, expected_resp.addr);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > 2 * (TOTAL_REQUESTS + stall_cycles) + 100)
		begin
			$display("Timeout after %0d cycles with %0d responses outstanding", cycle_count,
				expect_q.size());
			$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		logic [1:0] op_bits;
		logic [1:0] tag_bits;
		logic [1:0] set_bits;
		clk = 1'b0;
		reset = 1'b1;
		stall_i = 1'b0;
		req_valid_i = 1'b0;
		req_op_i = l2_pkg::L2_OP_READ;
		req_addr_i = '0;

		start_test();
		for (int s = 0; s < 16; s++)
			issue(l2_pkg::L2_OP_READ, {12'h3c1, 4'(s)});
		for (int s = 0; s < 16; s++)
			issue(l2_pkg::L2_OP_READ, {12'h3c1, 4'(s)});
		finish_test("cold misses in every set then hits on way 0");

		start_test();
		for (int i = 0; i < 5; i++)
			issue(l2_pkg::L2_OP_WRITE, {12'h100 + 12'(i), 4'h5});
		finish_test("writes fill one set and evict a dirty line");

		start_test();
		issue(l2_pkg::L2_OP_WRITE, 16'h2a77);
		issue(l2_pkg::L2_OP_FLUSH, 16'h2a77);
		issue(l2_pkg::L2_OP_READ, 16'h2a77);
		issue(l2_pkg::L2_OP_FLUSH, 16'h5557);
		issue(l2_pkg::L2_OP_FLUSH, 16'h2a77);
		finish_test("flush of dirty, clean and absent lines");

		start_test();
		issue(l2_pkg::L2_OP_READ, 16'h4443);
		issue(l2_pkg::L2_OP_READ, 16'h4443);
		issue(l2_pkg::L2_OP_WRITE, 16'h7773);
		issue(l2_pkg::L2_OP_WRITE, 16'h7773);
		issue(l2_pkg::L2_OP_FLUSH, 16'h4443);
		issue(l2_pkg::L2_OP_READ, 16'h4443);
		finish_test("back-to-back requests to one set");

		start_test();
		random_stall = 1'b1;
		for (int i = 0; i < RANDOM_REQUESTS; i++)
		begin
			op_bits = 2'(random_bits(2));
			tag_bits = 2'(random_bits(2));
			set_bits = 2'(random_bits(2));
			issue(op_bits == 2'd1 ? l2_pkg::L2_OP_WRITE
				: op_bits == 2'd2 ? l2_pkg::L2_OP_FLUSH : l2_pkg::L2_OP_READ,
				{10'd0, tag_bits, 2'd0, set_bits});
		end
		random_stall = 1'b0;
		finish_test("random requests with random stalls");

		$display("Tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/l2_pkg.sv
hw/sram_1r1w.sv
hw/cache_lru.sv
hw/l2_tag_stage.sv
hw/l2_update_stage.sv
hw/l2_tag_pipeline.sv
verification/tb_l2_tag_pipeline.sv

/* Bender.yml */
package:
  name: l2_tag_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/l2_pkg.sv
      - hw/sram_1r1w.sv
      - hw/cache_lru.sv
      - hw/l2_tag_stage.sv
      - hw/l2_update_stage.sv
      - hw/l2_tag_pipeline.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_l2_tag_pipeline.sv
